// ==== logic/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;

    // Tag 0 means the value is already in the register file
    typedef logic [4:0]  tag_t;

    localparam int MAX_ROB = 15;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_ADDI = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8
    } alu_op_e;

    typedef struct packed {
        alu_op_e    op;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] shamt;
        logic [7:0] pad;
    } r_fmt_t;

    typedef struct packed {
        alu_op_e     op;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [17:0] imm;
    } i_fmt_t;

    // op, rd and rs sit in the same bits in both views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/alu_issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alu_issue_if;
    logic             valid;
    ooo_pkg::alu_op_e op;
    ooo_pkg::tag_t    tag;
    ooo_pkg::data_t   a;
    ooo_pkg::data_t   b;
    logic [4:0]       shamt;
    logic             ready;

    // Station side
    modport source (
        output valid, op, tag, a, b, shamt,
        input  ready
    );

    // Execution unit side
    modport sink (
        input  valid, op, tag, a, b, shamt,
        output ready
    );
endinterface

`default_nettype wire

// ==== logic/rob_read_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rob_read_if;
    ooo_pkg::tag_t  tag1;
    ooo_pkg::tag_t  tag2;
    logic           ready1;
    logic           ready2;
    ooo_pkg::data_t value1;
    ooo_pkg::data_t value2;

    // Tags come from the rename table
    modport request (
        output tag1, tag2,
        input  ready1, ready2, value1, value2
    );

    // Combinational answer from the reorder buffer
    modport reply (
        input  tag1, tag2,
        output ready1, ready2, value1, value2
    );
endinterface

`default_nettype wire

// ==== logic/rename_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  ooo_pkg::instr_u   instr,
    input  ooo_pkg::tag_t     alloc_tag,
    output ooo_pkg::data_t    rs_val,
    output ooo_pkg::data_t    rt_val,
    output ooo_pkg::tag_t     rs_tag,
    output ooo_pkg::tag_t     rt_tag,
    input  logic              commit_valid,
    input  ooo_pkg::reg_idx_t commit_rd,
    input  ooo_pkg::tag_t     commit_tag,
    input  ooo_pkg::data_t    commit_data
);
    ooo_pkg::data_t    regs [32];
    ooo_pkg::tag_t     tags [32];
    ooo_pkg::reg_idx_t dst;

    assign dst = instr.r.rd;

    // Entry 0 is never written, so r0 reads zero with no producer
    assign rs_val = regs[instr.r.rs];
    assign rt_val = regs[instr.r.rt];
    assign rs_tag = tags[instr.r.rs];
    assign rt_tag = tags[instr.r.rt];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // Only drop the tag if no younger writer renamed it meanwhile
                if (tags[commit_rd] == commit_tag)
                    tags[commit_rd] <= '0;
            end
            // Later assignment, so a new producer beats the clear above
            if (dispatch && dst != '0)
                tags[dst] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  ooo_pkg::reg_idx_t rd,
    output ooo_pkg::tag_t     alloc_tag,
    output logic              full,
    input  logic              cdb_valid,
    input  ooo_pkg::tag_t     cdb_tag,
    input  ooo_pkg::data_t    cdb_data,
    rob_read_if.reply         rd_port,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::tag_t     commit_tag,
    output ooo_pkg::data_t    commit_data
);
    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [ROB_DEPTH-1:0] ent_rdy;
    ooo_pkg::reg_idx_t    ent_rd  [ROB_DEPTH];
    ooo_pkg::data_t       ent_val [ROB_DEPTH];
    logic [IDX_W-1:0]     cdb_idx;
    logic [IDX_W-1:0]     idx1;
    logic [IDX_W-1:0]     idx2;

    // Entry k answers to tag k+1
    function automatic logic [IDX_W-1:0] tag_to_idx(input ooo_pkg::tag_t t);
        return IDX_W'(t - 1'b1);
    endfunction

    function automatic logic [IDX_W-1:0] wrap_inc(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(ROB_DEPTH));
    assign alloc_tag = ooo_pkg::tag_t'(tail) + 1'b1;
    assign cdb_idx   = tag_to_idx(cdb_tag);

    // Head retires once its result has landed
    assign commit_valid = (count != '0) && ent_rdy[head];
    assign commit_rd    = ent_rd[head];
    assign commit_tag   = ooo_pkg::tag_t'(head) + 1'b1;
    assign commit_data  = ent_val[head];

    // Operand lookup for the station
    assign idx1           = tag_to_idx(rd_port.tag1);
    assign idx2           = tag_to_idx(rd_port.tag2);
    assign rd_port.ready1 = (rd_port.tag1 != '0) && ent_rdy[idx1];
    assign rd_port.ready2 = (rd_port.tag2 != '0) && ent_rdy[idx2];
    assign rd_port.value1 = ent_val[idx1];
    assign rd_port.value2 = ent_val[idx2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            ent_rdy <= '0;
        end else begin
            if (cdb_valid)
                ent_rdy[cdb_idx] <= 1'b1;
            // Freed entry leaves not ready for its next owner
            if (commit_valid) begin
                ent_rdy[head] <= 1'b0;
                head          <= wrap_inc(head);
            end
            if (dispatch)
                tail <= wrap_inc(tail);
            case ({dispatch, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch)
            ent_rd[tail] <= rd;
        if (cdb_valid)
            ent_val[cdb_idx] <= cdb_data;
    end

endmodule

`default_nettype wire

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch,
    input  ooo_pkg::instr_u instr,
    input  ooo_pkg::tag_t   alloc_tag,
    input  ooo_pkg::data_t  rs_val,
    input  ooo_pkg::data_t  rt_val,
    input  ooo_pkg::tag_t   rs_tag,
    input  ooo_pkg::tag_t   rt_tag,
    rob_read_if.request     rob_rd,
    input  logic            cdb_valid,
    input  ooo_pkg::tag_t   cdb_tag,
    input  ooo_pkg::data_t  cdb_data,
    output logic            full,
    alu_issue_if.source     issue
);
    localparam int SLOT_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    logic [RS_DEPTH-1:0] busy;
    ooo_pkg::alu_op_e    s_op    [RS_DEPTH];
    ooo_pkg::tag_t       s_dst   [RS_DEPTH];
    ooo_pkg::data_t      s_a     [RS_DEPTH];
    ooo_pkg::data_t      s_b     [RS_DEPTH];
    ooo_pkg::tag_t       s_a_tag [RS_DEPTH];
    ooo_pkg::tag_t       s_b_tag [RS_DEPTH];
    logic [4:0]          s_shamt [RS_DEPTH];

    logic [SLOT_W-1:0] free_idx;
    logic [SLOT_W-1:0] sel_idx;
    logic              sel_found;
    ooo_pkg::alu_op_e  d_op;
    ooo_pkg::data_t    d_a;
    ooo_pkg::data_t    d_b;
    ooo_pkg::tag_t     d_a_tag;
    ooo_pkg::tag_t     d_b_tag;

    // Register file, then reorder buffer, then this cycle's broadcast
    function automatic void resolve(
        input  ooo_pkg::tag_t  src_tag,
        input  ooo_pkg::data_t reg_val,
        input  logic           rob_ready,
        input  ooo_pkg::data_t rob_val,
        output ooo_pkg::data_t val,
        output ooo_pkg::tag_t  wait_tag
    );
        val      = reg_val;
        wait_tag = '0;
        if (src_tag != '0) begin
            if (rob_ready)
                val = rob_val;
            else if (cdb_valid && cdb_tag == src_tag)
                val = cdb_data;
            else
                wait_tag = src_tag;
        end
    endfunction

    assign d_op        = instr.r.op;
    assign full        = &busy;
    assign rob_rd.tag1 = rs_tag;
    assign rob_rd.tag2 = rt_tag;

    always_comb begin
        resolve(rs_tag, rs_val, rob_rd.ready1, rob_rd.value1, d_a, d_a_tag);
        resolve(rt_tag, rt_val, rob_rd.ready2, rob_rd.value2, d_b, d_b_tag);
        if (d_op == ooo_pkg::OP_ADDI) begin
            d_b     = {{14{instr.i.imm[17]}}, instr.i.imm};
            d_b_tag = '0;
        end else if (d_op == ooo_pkg::OP_SLL || d_op == ooo_pkg::OP_SRL) begin
            d_b     = '0;
            d_b_tag = '0;
        end
    end

    // Walk downwards so the lowest index wins for both searches
    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i])
                free_idx = SLOT_W'(i);
            if (busy[i] && s_a_tag[i] == '0 && s_b_tag[i] == '0) begin
                sel_idx   = SLOT_W'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign issue.valid = sel_found;
    assign issue.op    = s_op[sel_idx];
    assign issue.tag   = s_dst[sel_idx];
    assign issue.a     = s_a[sel_idx];
    assign issue.b     = s_b[sel_idx];
    assign issue.shamt = s_shamt[sel_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (issue.valid && issue.ready)
                busy[sel_idx] <= 1'b0;
            if (dispatch)
                busy[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && s_a_tag[i] != '0 && s_a_tag[i] == cdb_tag) begin
                s_a[i]     <= cdb_data;
                s_a_tag[i] <= '0;
            end
            if (cdb_valid && s_b_tag[i] != '0 && s_b_tag[i] == cdb_tag) begin
                s_b[i]     <= cdb_data;
                s_b_tag[i] <= '0;
            end
        end
        if (dispatch) begin
            s_op[free_idx]    <= d_op;
            s_dst[free_idx]   <= alloc_tag;
            s_a[free_idx]     <= d_a;
            s_b[free_idx]     <= d_b;
            s_a_tag[free_idx] <= d_a_tag;
            s_b_tag[free_idx] <= d_b_tag;
            s_shamt[free_idx] <= instr.r.shamt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic           clk,
    input  logic           rst,
    alu_issue_if.sink      issue,
    output logic           cdb_valid,
    output ooo_pkg::tag_t  cdb_tag,
    output ooo_pkg::data_t cdb_data
);
    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] SHIFT = 2'd1;
    localparam logic [1:0] DONE  = 2'd2;

    logic [1:0]       state;
    logic [4:0]       steps;
    ooo_pkg::data_t   acc;
    ooo_pkg::data_t   alu_res;
    ooo_pkg::tag_t    tag_q;
    ooo_pkg::alu_op_e op_q;
    logic             is_shift;
    logic             accept;

    assign issue.ready = (state == IDLE);
    assign accept      = issue.valid && issue.ready;
    assign is_shift    = (issue.op == ooo_pkg::OP_SLL) || (issue.op == ooo_pkg::OP_SRL);

    always_comb begin
        case (issue.op)
            ooo_pkg::OP_ADD:  alu_res = issue.a + issue.b;
            ooo_pkg::OP_ADDI: alu_res = issue.a + issue.b;
            ooo_pkg::OP_SUB:  alu_res = issue.a - issue.b;
            ooo_pkg::OP_AND:  alu_res = issue.a & issue.b;
            ooo_pkg::OP_OR:   alu_res = issue.a | issue.b;
            ooo_pkg::OP_XOR:  alu_res = issue.a ^ issue.b;
            ooo_pkg::OP_SLT:  alu_res = {31'd0, $signed(issue.a) < $signed(issue.b)};
            // Shifts load the unshifted operand and step it later
            ooo_pkg::OP_SLL:  alu_res = issue.a;
            ooo_pkg::OP_SRL:  alu_res = issue.a;
            default:          alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            steps <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        steps <= issue.shamt;
                        // shamt of 0 needs no shift cycles at all
                        state <= (is_shift && issue.shamt != '0) ? SHIFT : DONE;
                    end
                end
                SHIFT: begin
                    steps <= steps - 1'b1;
                    if (steps == 5'd1)
                        state <= DONE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc   <= alu_res;
            tag_q <= issue.tag;
            op_q  <= issue.op;
        end else if (state == SHIFT) begin
            acc <= (op_q == ooo_pkg::OP_SLL) ? acc << 1 : acc >> 1;
        end
    end

    // One broadcast cycle per accepted operation
    assign cdb_valid = (state == DONE);
    assign cdb_tag   = tag_q;
    assign cdb_data  = acc;

endmodule

`default_nettype wire

// ==== logic/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
    parameter int ROB_DEPTH = 8,
    parameter int RS_DEPTH  = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  logic [31:0]       instr,
    output logic              full,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::data_t    commit_data
);
    ooo_pkg::instr_u instr_w;
    logic            accept;
    logic            rob_full;
    logic            rs_full;
    ooo_pkg::tag_t   alloc_tag;
    ooo_pkg::tag_t   rs_tag;
    ooo_pkg::tag_t   rt_tag;
    ooo_pkg::tag_t   commit_tag;
    ooo_pkg::data_t  rs_val;
    ooo_pkg::data_t  rt_val;
    logic            cdb_valid;
    ooo_pkg::tag_t   cdb_tag;
    ooo_pkg::data_t  cdb_data;

    alu_issue_if issue_bus ();
    rob_read_if  rob_bus ();

    assign instr_w = instr;
    assign full    = rob_full | rs_full;
    // A strobe while full is dropped here
    assign accept  = dispatch && !full;

    rename_regfile regfile_i (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (accept),
        .instr        (instr_w),
        .alloc_tag    (alloc_tag),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .rs_tag       (rs_tag),
        .rt_tag       (rt_tag),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_data  (commit_data)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (accept),
        .rd           (instr_w.r.rd),
        .alloc_tag    (alloc_tag),
        .full         (rob_full),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .rd_port      (rob_bus.reply),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_data  (commit_data)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_i (
        .clk       (clk),
        .rst       (rst),
        .dispatch  (accept),
        .instr     (instr_w),
        .alloc_tag (alloc_tag),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .rs_tag    (rs_tag),
        .rt_tag    (rt_tag),
        .rob_rd    (rob_bus.request),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .full      (rs_full),
        .issue     (issue_bus.source)
    );

    exec_unit exec_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue_bus.sink),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data)
    );

endmodule

`default_nettype wire

// ==== tb/ooo_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_properties (
    input logic clk,
    input logic rst,
    input logic full,
    input logic commit_valid,
    input logic issue_valid,
    input logic issue_ready,
    input logic cdb_valid
);

    // Outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) rst |-> (!full && !commit_valid))
        else $error("full or commit_valid high during reset");

    // Station keeps offering until the unit takes it
    issue_hold: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && !issue_ready) |=> issue_valid)
        else $error("issue valid dropped before ready");

    // Unit is busy from acceptance until its broadcast
    accept_busy: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_ready) |=> !issue_ready)
        else $error("execution unit ready right after an acceptance");

    cdb_single: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |=> !cdb_valid)
        else $error("broadcast longer than one cycle");

endmodule

`default_nettype wire

// ==== tb/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;
    localparam int ROB_DEPTH  = 8;
    localparam int RS_DEPTH   = 4;
    localparam int N_INSTR    = 300;
    localparam int MAX_CYCLES = N_INSTR * (32 + ROB_DEPTH);

    logic              clk;
    logic              rst;
    logic              dispatch;
    logic [31:0]       instr;
    logic              full;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::data_t    commit_data;

    // Sequential reference state and the commits it still expects
    logic [31:0]       model_regs [32];
    ooo_pkg::reg_idx_t exp_rd_q   [$];
    ooo_pkg::data_t    exp_data_q [$];
    ooo_pkg::reg_idx_t exp_rd;
    ooo_pkg::data_t    exp_data;

    int errors     = 0;
    int dispatched = 0;
    int committed  = 0;
    int cycles     = 0;
    bit saw_full   = 1'b0;

    ooo_core #(.ROB_DEPTH(ROB_DEPTH), .RS_DEPTH(RS_DEPTH)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .instr        (instr),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    bind ooo_core ooo_core_properties props_i (
        .clk          (clk),
        .rst          (rst),
        .full         (full),
        .commit_valid (commit_valid),
        .issue_valid  (issue_bus.valid),
        .issue_ready  (issue_bus.ready),
        .cdb_valid    (cdb_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Registers limited to r0..r7 so that dependencies are frequent
    function automatic logic [31:0] random_instr();
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  shamt;
        logic [17:0] imm;
        op  = 4'($urandom_range(8, 0));
        rd  = 5'($urandom_range(7, 0));
        rs  = 5'($urandom_range(7, 0));
        rt  = 5'($urandom_range(7, 0));
        imm = 18'($urandom);
        // Edge shift amounts show up often
        case ($urandom_range(3, 0))
            0:       shamt = 5'd0;
            1:       shamt = 5'd31;
            default: shamt = 5'($urandom);
        endcase
        if (op == ooo_pkg::OP_ADDI)
            return {op, rd, rs, imm};
        return {op, rd, rs, rt, shamt, 8'($urandom)};
    endfunction

    // Field positions: op 31:28, rd 27:23, rs 22:18, rt 17:13, shamt 12:8, imm 17:0
    function automatic logic [31:0] model_result(input logic [31:0] w);
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_ext;
        logic [4:0]  sh;
        op      = w[31:28];
        a       = model_regs[w[22:18]];
        b       = model_regs[w[17:13]];
        sh      = w[12:8];
        imm_ext = {{14{w[17]}}, w[17:0]};
        case (op)
            ooo_pkg::OP_ADD:  return a + b;
            ooo_pkg::OP_SUB:  return a - b;
            ooo_pkg::OP_AND:  return a & b;
            ooo_pkg::OP_OR:   return a | b;
            ooo_pkg::OP_XOR:  return a ^ b;
            ooo_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::OP_ADDI: return a + imm_ext;
            ooo_pkg::OP_SLL:  return a << sh;
            ooo_pkg::OP_SRL:  return a >> sh;
            default:          return 32'd0;
        endcase
    endfunction

    task automatic push_model(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] v;
        rd = w[27:23];
        v  = model_result(w);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(v);
        // r0 still commits its result but keeps reading zero
        if (rd != 5'd0)
            model_regs[rd] = v;
    endtask

    task automatic finish_run();
        $display("errors %0d, dispatched %0d, committed %0d", errors, dispatched, committed);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Commit outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            committed++;
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("Commit at %0t with no instruction outstanding in the model", $time);
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (commit_rd !== exp_rd) begin
                    errors++;
                    $display("ERR %0t commit_rd expected %0d got %0d",
                             $time, exp_rd, commit_rd);
                end
                if (commit_data !== exp_data) begin
                    errors++;
                    $display("ERR %0t commit_data expected %08h got %08h",
                             $time, exp_data, commit_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d instructions committed",
                     cycles, committed, dispatched);
            finish_run();
        end
    end

    initial begin
        logic [31:0] word;
        bit          burst;
        void'($urandom(32'h681d4ba8));
        rst      = 1'b1;
        dispatch = 1'b0;
        instr    = 32'd0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        while (dispatched < N_INSTR) begin
            @(posedge clk);
            #1;
            dispatch = 1'b0;
            // Every outstanding instruction holds one buffer entry
            if ((dispatched - committed) >= ROB_DEPTH && full !== 1'b1) begin
                errors++;
                $display("ERR %0t full expected 1 got %b", $time, full);
            end
            if (dispatched == committed && full !== 1'b0) begin
                errors++;
                $display("ERR %0t full expected 0 got %b", $time, full);
            end
            // Middle third dispatches back to back until full
            burst = (dispatched >= 100) && (dispatched < 200);
            if (burst && full)
                saw_full = 1'b1;
            if (!full && (burst || $urandom_range(99, 0) < 60)) begin
                word     = random_instr();
                instr    = word;
                dispatch = 1'b1;
                push_model(word);
                dispatched++;
            end
        end
        @(posedge clk);
        #1 dispatch = 1'b0;

        while (committed < dispatched)
            @(posedge clk);
        // Extra cycles catch any stray commit
        repeat (10) @(posedge clk);

        if (committed != dispatched) begin
            errors++;
            $display("Committed %0d instructions but dispatched %0d", committed, dispatched);
        end
        if (!saw_full) begin
            errors++;
            $display("Core never reported full during back to back dispatch");
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/ooo_pkg.sv
logic/alu_issue_if.sv
logic/rob_read_if.sv
logic/rename_regfile.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/exec_unit.sv
logic/ooo_core.sv
tb/ooo_core_properties.sv
tb/ooo_core_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ooo_core_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@! grep -q "TEST FAILED" sim.log
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
